// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_cpu_backend
FILELIST = filelist.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = TEST RESULT: FAIL

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
rtl/cpu_pkg.sv
rtl/pipe_reg.sv
rtl/register_file.sv
rtl/execute_unit.sv
rtl/hazard_unit.sv
rtl/memory_writeback.sv
rtl/cpu_backend.sv
sim/clock_gen.sv
sim/cpu_backend_props.sv
sim/tb_cpu_backend.sv

// ==== rtl/cpu_backend.sv ====
module cpu_backend import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  issue_valid,
  input  issue_t                issue,
  output logic                  issue_ready,
  output logic                  wb_valid,
  output logic [REG_ADDR_W-1:0] wb_reg,
  output logic [DATA_W-1:0]     wb_data,
  output logic                  halted
);

  logic [DATA_W-1:0] rd_data_a;
  logic [DATA_W-1:0] rd_data_b;
  fwd_sel_e          fwd_a;
  fwd_sel_e          fwd_b;
  logic              bubble;
  logic              store_fwd;
  ex_mem_t           ex_mem_d;  // Built in EX
  ex_mem_t           ex_mem;    // Held for MEM
  mem_wb_t           mem_wb_d;
  mem_wb_t           mem_wb;    // Held for write-back

  //////////////////////////////////////////////////
  // Execute
  //////////////////////////////////////////////////
  register_file u_register_file (
    .clk       (clk),
    .reset     (reset),
    .rd_addr_a (issue.src_reg1),
    .rd_addr_b (issue.src_reg2),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wr_en     (wb_valid),   // Write-back writes at the edge that ends it
    .wr_addr   (wb_reg),
    .wr_data   (wb_data)
  );

  hazard_unit u_hazard_unit (
    .clk         (clk),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue       (issue),
    .ex_mem      (ex_mem),
    .mem_wb      (mem_wb),
    .issue_ready (issue_ready),
    .bubble      (bubble),
    .fwd_a       (fwd_a),
    .fwd_b       (fwd_b),
    .store_fwd   (store_fwd),
    .halted      (halted)
  );

  execute_unit u_execute_unit (
    .issue      (issue),
    .rd_data_a  (rd_data_a),
    .rd_data_b  (rd_data_b),
    .ex_alu_out (ex_mem.alu_out),
    .wb_data    (wb_data),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .ex_mem_d   (ex_mem_d)
  );

  //////////////////////////////////////////////////
  // Stage registers and memory
  //////////////////////////////////////////////////
  pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem_reg (
    .clk    (clk),
    .reset  (reset),
    .bubble (bubble),   // Empty slot when nothing was accepted
    .d      (ex_mem_d),
    .q      (ex_mem)
  );

  // Memory controls end here, the rest moves on
  assign mem_wb_d = '{pc_next: ex_mem.pc_next, alu_out: ex_mem.alu_out, wb: ex_mem.wb};

  pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb_reg (
    .clk    (clk),
    .reset  (reset),
    .bubble (1'b0),     // MEM always advances
    .d      (mem_wb_d),
    .q      (mem_wb)
  );

  memory_writeback u_memory_writeback (
    .clk       (clk),
    .reset     (reset),
    .ex_mem    (ex_mem),
    .mem_wb    (mem_wb),
    .store_fwd (store_fwd),
    .wb_valid  (wb_valid),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data)
  );

endmodule

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

  //////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////
  localparam int DATA_W      = 16;  // Data word and address word
  localparam int REG_ADDR_W  = 4;   // Register ID
  localparam int NUM_REGS    = 16;  // Register 0 always reads as zero
  localparam int DMEM_ADDR_W = 8;   // Low bits of the ALU result index the data memory
  localparam int DMEM_DEPTH  = 256; // Data memory words

  //////////////////////////////////////////////////
  // ALU opcodes and operand sources
  //////////////////////////////////////////////////
  // Shifts take their amount from the low 4 bits of operand b
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLL    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_PASS_B = 4'd8   // Operand b straight through, used for load immediate
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_REG    = 2'd0,  // Register file read port
    FWD_EX_MEM = 2'd1,  // ALU result held in EX/MEM
    FWD_WB     = 2'd2   // Value on the write-back port
  } fwd_sel_e;

  //////////////////////////////////////////////////
  // Pipeline payloads
  //////////////////////////////////////////////////
  // Memory stage controls, 18 bits with the write data on top
  typedef struct packed {
    logic [DATA_W-1:0] mem_write_data;
    logic              mem_enable;
    logic              mem_write;
  } mem_ctrl_t;

  // Write-back controls, 8 bits with the destination on top
  typedef struct packed {
    logic [REG_ADDR_W-1:0] reg_rd;
    logic                  reg_write;
    logic                  mem_to_reg; // Result comes from the data memory
    logic                  hlt;
    logic                  pcs;        // Result is the next PC
  } wb_ctrl_t;

  // Decoded operation as it arrives on the issue port
  typedef struct packed {
    logic [DATA_W-1:0]     pc_next;
    alu_op_e               alu_op;
    logic [REG_ADDR_W-1:0] src_reg1;
    logic [REG_ADDR_W-1:0] src_reg2;
    logic [DATA_W-1:0]     imm;
    logic                  use_imm;    // Operand b is the immediate
    logic                  mem_enable;
    logic                  mem_write;
    wb_ctrl_t              wb;
  } issue_t;

  typedef struct packed {
    logic [DATA_W-1:0]     pc_next;
    logic [DATA_W-1:0]     alu_out;
    logic [REG_ADDR_W-1:0] src_reg2;   // Kept for the store data check in MEM
    mem_ctrl_t             mem;
    wb_ctrl_t              wb;
  } ex_mem_t;

  typedef struct packed {
    logic [DATA_W-1:0] pc_next;
    logic [DATA_W-1:0] alu_out;
    wb_ctrl_t          wb;
  } mem_wb_t;

endpackage

// ==== rtl/execute_unit.sv ====
module execute_unit import cpu_pkg::*; (
  input  issue_t            issue,
  input  logic [DATA_W-1:0] rd_data_a,
  input  logic [DATA_W-1:0] rd_data_b,
  input  logic [DATA_W-1:0] ex_alu_out,  // Result of the operation one ahead
  input  logic [DATA_W-1:0] wb_data,     // Result of the operation two ahead
  input  fwd_sel_e          fwd_a,
  input  fwd_sel_e          fwd_b,
  output ex_mem_t           ex_mem_d
);

  logic [DATA_W-1:0] op_a;    // First ALU operand after forwarding
  logic [DATA_W-1:0] reg_b;   // Second register value after forwarding
  logic [DATA_W-1:0] op_b;    // Second ALU operand
  logic [DATA_W-1:0] alu_out;
  logic [3:0]        shamt;

  // Operand selection
  always_comb begin
    unique case (fwd_a)
      FWD_EX_MEM: op_a = ex_alu_out;
      FWD_WB:     op_a = wb_data;
      default:    op_a = rd_data_a;
    endcase
    unique case (fwd_b)
      FWD_EX_MEM: reg_b = ex_alu_out;
      FWD_WB:     reg_b = wb_data;
      default:    reg_b = rd_data_b;
    endcase
  end

  assign op_b  = issue.use_imm ? issue.imm : reg_b; // Immediate replaces the second register
  assign shamt = op_b[3:0];

  // ALU
  always_comb begin
    unique case (issue.alu_op)
      ALU_ADD:    alu_out = op_a + op_b;
      ALU_SUB:    alu_out = op_a - op_b;
      ALU_AND:    alu_out = op_a & op_b;
      ALU_OR:     alu_out = op_a | op_b;
      ALU_XOR:    alu_out = op_a ^ op_b;
      ALU_SLL:    alu_out = op_a << shamt;
      ALU_SRL:    alu_out = op_a >> shamt;
      ALU_SRA:    alu_out = DATA_W'($signed(op_a) >>> shamt); // Sign bit fills in
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = '0;
    endcase
  end

  // Pack the payload for EX/MEM. A store writes the forwarded second register,
  // the address comes from the ALU
  always_comb begin
    ex_mem_d.pc_next            = issue.pc_next;
    ex_mem_d.alu_out            = alu_out;
    ex_mem_d.src_reg2           = issue.src_reg2;
    ex_mem_d.mem.mem_write_data = reg_b;
    ex_mem_d.mem.mem_enable     = issue.mem_enable;
    ex_mem_d.mem.mem_write      = issue.mem_write;
    ex_mem_d.wb                 = issue.wb;
  end

endmodule

// ==== rtl/hazard_unit.sv ====
module hazard_unit import cpu_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     issue_valid,
  input  issue_t   issue,
  input  ex_mem_t  ex_mem,
  input  mem_wb_t  mem_wb,
  output logic     issue_ready,
  output logic     bubble,     // Low only when an operation is accepted
  output fwd_sel_e fwd_a,
  output fwd_sel_e fwd_b,
  output logic     store_fwd,  // Memory writes the write-back value as store data
  output logic     halted
);

  logic ex_fwd_ok;    // EX/MEM result is ready for the ALU
  logic ex_late;      // EX/MEM result exists only after the memory stage
  logic wb_fwd_ok;
  logic stall;
  logic started_q;    // Low in reset and in the cycle after it
  logic halt_taken_q; // Set once a halt goes in and closes the port
  logic halted_q;

  //////////////////////////////////////////////////
  // Forwarding selects
  //////////////////////////////////////////////////
  assign ex_fwd_ok = ex_mem.wb.reg_write && (ex_mem.wb.reg_rd != '0)
                     && !ex_mem.wb.mem_to_reg && !ex_mem.wb.pcs;
  assign ex_late   = ex_mem.wb.reg_write && (ex_mem.wb.reg_rd != '0)
                     && (ex_mem.wb.mem_to_reg || ex_mem.wb.pcs);
  assign wb_fwd_ok = mem_wb.wb.reg_write && (mem_wb.wb.reg_rd != '0);

  // The nearer producer wins
  function automatic fwd_sel_e pick_fwd(input logic [REG_ADDR_W-1:0] src);
    fwd_sel_e sel;
    if (ex_fwd_ok && (ex_mem.wb.reg_rd == src)) begin
      sel = FWD_EX_MEM;
    end else if (wb_fwd_ok && (mem_wb.wb.reg_rd == src)) begin
      sel = FWD_WB;
    end else begin
      sel = FWD_REG;
    end
    return sel;
  endfunction

  always_comb begin
    fwd_a = pick_fwd(issue.src_reg1);
    fwd_b = pick_fwd(issue.src_reg2);
  end

  //////////////////////////////////////////////////
  // Stall, store data forwarding and handshake
  //////////////////////////////////////////////////
  // A load or PCS result feeding an ALU source holds the issue for one cycle
  assign stall = ex_late && ((ex_mem.wb.reg_rd == issue.src_reg1)
                 || (!issue.use_imm && (ex_mem.wb.reg_rd == issue.src_reg2)));

  // Store right behind a load or PCS of its data register
  assign store_fwd = ex_mem.mem.mem_enable && ex_mem.mem.mem_write && wb_fwd_ok
                     && (mem_wb.wb.mem_to_reg || mem_wb.wb.pcs)
                     && (mem_wb.wb.reg_rd == ex_mem.src_reg2);

  assign issue_ready = started_q && !halt_taken_q && !stall; // Independent of issue_valid
  assign bubble      = !(issue_valid && issue_ready);
  assign halted      = halted_q || mem_wb.wb.hlt;            // Rises with the halt in MEM/WB

  always_ff @(posedge clk) begin
    if (reset) begin
      started_q    <= 1'b0;
      halt_taken_q <= 1'b0;
      halted_q     <= 1'b0;
    end else begin
      started_q <= 1'b1;
      if (issue_valid && issue_ready && issue.wb.hlt) begin
        halt_taken_q <= 1'b1;   // Sticky until reset
      end
      if (mem_wb.wb.hlt) begin
        halted_q <= 1'b1;
      end
    end
  end

endmodule

// ==== rtl/memory_writeback.sv ====
module memory_writeback import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  ex_mem_t               ex_mem,
  input  mem_wb_t               mem_wb,
  input  logic                  store_fwd,
  output logic                  wb_valid,
  output logic [REG_ADDR_W-1:0] wb_reg,
  output logic [DATA_W-1:0]     wb_data
);

  logic [DATA_W-1:0]      dmem [DMEM_DEPTH];
  logic [DMEM_ADDR_W-1:0] addr;
  logic [DATA_W-1:0]      store_data;
  logic [DATA_W-1:0]      rd_q;      // Read word, lines up with MEM/WB

  assign addr       = ex_mem.alu_out[DMEM_ADDR_W-1:0];
  // Loaded word from the operation one ahead replaces stale store data
  assign store_data = store_fwd ? wb_data : ex_mem.mem.mem_write_data;

  //////////////////////////////////////////////////
  // Data memory
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DMEM_DEPTH; i++) begin
        dmem[i] <= '0;
      end
    end else if (ex_mem.mem.mem_enable && ex_mem.mem.mem_write) begin
      dmem[addr] <= store_data;
    end
  end

  // Synchronous read port
  always_ff @(posedge clk) begin
    if (!(ex_mem.mem.mem_enable && ex_mem.mem.mem_write)) begin
      rd_q <= dmem[addr];
    end
  end

  //////////////////////////////////////////////////
  // Write-back select
  //////////////////////////////////////////////////
  always_comb begin
    if (mem_wb.wb.mem_to_reg) begin
      wb_data = rd_q;                 // Load
    end else if (mem_wb.wb.pcs) begin
      wb_data = mem_wb.pc_next;       // Return address
    end else begin
      wb_data = mem_wb.alu_out;
    end
  end

  assign wb_valid = mem_wb.wb.reg_write;
  assign wb_reg   = mem_wb.wb.reg_rd;

endmodule

// ==== rtl/pipe_reg.sv ====
// Generic stage register, the same block serves EX/MEM and MEM/WB
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     bubble,  // Load a no-op instead of d
  input  payload_t d,
  output payload_t q
);

  // An all-zero payload has every control bit clear, so it behaves as a no-op
  // in the stages that follow

  always_ff @(posedge clk) begin
    if (reset) begin
      q <= '0;              // Pipeline empties on reset
    end else if (bubble) begin
      q <= '0;              // Nothing accepted this cycle
    end else begin
      q <= d;               // Stages always advance
    end
  end

endmodule

// ==== rtl/register_file.sv ====
module register_file import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [REG_ADDR_W-1:0] rd_addr_a,
  input  logic [REG_ADDR_W-1:0] rd_addr_b,
  output logic [DATA_W-1:0]     rd_data_a,
  output logic [DATA_W-1:0]     rd_data_b,
  input  logic                  wr_en,
  input  logic [REG_ADDR_W-1:0] wr_addr,
  input  logic [DATA_W-1:0]     wr_data
);

  logic [DATA_W-1:0] regs [NUM_REGS]; // Entry 0 exists but is never read

  // Register 0 reads as zero
  // A value still on the write-back port reaches EX through the forward select
  assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
  assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin    // Writes to register 0 are dropped
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

// ==== sim/clock_gen.sv ====
module clock_gen (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;  // 10 ns period
    end
  end

  // Reset covers four rising edges and drops right after the last one
  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// ==== sim/cpu_backend_props.sv ====
module cpu_backend_props import cpu_pkg::*; (
  input logic   clk,
  input logic   reset,
  input logic   issue_valid,
  input issue_t issue,
  input logic   issue_ready,
  input logic   wb_valid,
  input logic   halted
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;  // Read back by the testbench when the run closes

  // One reset edge clears every stage, so the ports stay quiet until the cycle after
  assert property (@(posedge clk) $past(reset) |-> !issue_ready && !wb_valid && !halted)
    else begin
      fail_count++;
      $error("Issue port, write-back or halt active during reset");
    end

  // Halt is sticky until the next reset
  assert property (@(posedge clk) disable iff (reset) !$fell(halted))
    else begin
      fail_count++;
      $error("Halted dropped outside reset");
    end

  // A stalled operation must be held by the source
  assert property (@(posedge clk) disable iff (reset)
                   issue_valid && !issue_ready |=> issue_valid && $stable(issue))
    else begin
      fail_count++;
      $error("Issue changed while it was stalled");
    end

endmodule

// ==== sim/tb_cpu_backend.sv ====
module tb_cpu_backend import cpu_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  // Expected write-back, destination on top
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [DATA_W-1:0]     data;
  } wb_expect_t;

  logic                  clk;
  logic                  reset;
  logic                  issue_valid;
  issue_t                issue;
  logic                  issue_ready;
  logic                  wb_valid;
  logic [REG_ADDR_W-1:0] wb_reg;
  logic [DATA_W-1:0]     wb_data;
  logic                  halted;

  logic [DATA_W-1:0] model_regs [NUM_REGS];  // Register 0 is never written here
  logic [DATA_W-1:0] model_mem  [DMEM_DEPTH];
  wb_expect_t        expect_q [$];           // Write-backs the DUT still owes
  issue_t            program_q [$];
  logic [DATA_W-1:0] next_pc;
  int                mismatch_count;
  int                error_count;
  int                wb_count;
  int                expect_count;

  clock_gen u_clock_gen (.clk(clk), .reset(reset));

  cpu_backend DUT (
    .clk         (clk),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue       (issue),
    .issue_ready (issue_ready),
    .wb_valid    (wb_valid),
    .wb_reg      (wb_reg),
    .wb_data     (wb_data),
    .halted      (halted)
  );

  bind cpu_backend cpu_backend_props u_props (
    .clk         (clk),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue       (issue),
    .issue_ready (issue_ready),
    .wb_valid    (wb_valid),
    .halted      (halted)
  );

  //////////////////////////////////////////////////
  // Operation builders
  //////////////////////////////////////////////////
  // Mostly a handful of low registers, so operations lean on each other
  function automatic logic [REG_ADDR_W-1:0] pick_reg();
    if ($urandom_range(3) == 0) begin
      return REG_ADDR_W'($urandom_range(NUM_REGS - 1));
    end
    return REG_ADDR_W'($urandom_range(5));
  endfunction

  function automatic logic [REG_ADDR_W-1:0] pick_base();
    return ($urandom_range(3) == 0) ? pick_reg() : '0;  // Zero base keeps addresses small
  endfunction

  function automatic issue_t make_alu(input logic [REG_ADDR_W-1:0] rd,
                                      input logic [REG_ADDR_W-1:0] rs1,
                                      input logic [REG_ADDR_W-1:0] rs2);
    issue_t op;
    op              = '0;
    op.alu_op       = alu_op_e'(4'($urandom_range(8)));
    op.src_reg1     = rs1;
    op.src_reg2     = rs2;
    op.imm          = DATA_W'($urandom());
    op.use_imm      = 1'($urandom_range(1));
    op.wb.reg_rd    = rd;
    op.wb.reg_write = 1'b1;
    return op;
  endfunction

  // Load or store at base register plus offset
  function automatic issue_t make_mem(input logic store, input logic [REG_ADDR_W-1:0] data_reg,
                                      input logic [REG_ADDR_W-1:0] base, input logic [7:0] off);
    issue_t op;
    op            = '0;
    op.alu_op     = ALU_ADD;
    op.src_reg1   = base;
    op.imm        = {8'h00, off};
    op.use_imm    = 1'b1;
    op.mem_enable = 1'b1;
    op.mem_write  = store;
    if (store) begin
      op.src_reg2 = data_reg;     // Store data register
    end else begin
      op.wb.reg_rd     = data_reg;
      op.wb.reg_write  = 1'b1;
      op.wb.mem_to_reg = 1'b1;
    end
    return op;
  endfunction

  task automatic add_op(input issue_t op);
    op.pc_next = next_pc;
    next_pc    = next_pc + 16'd2;
    program_q.push_back(op);
  endtask

  task automatic generate_program(input int count);
    issue_t                op;
    logic [REG_ADDR_W-1:0] ra;
    logic [REG_ADDR_W-1:0] rb;
    logic [7:0]            addr;
    while (program_q.size() < count) begin
      ra   = pick_reg();
      rb   = pick_reg();
      addr = 8'($urandom_range(15));
      case ($urandom_range(9))
        0, 1, 2, 3: add_op(make_alu(ra, rb, pick_reg()));  // Dependent ALU chains
        4: begin                                           // Load, then use it in the ALU
          add_op(make_mem(1'b0, ra, pick_base(), addr));
          op = make_alu(rb, ra, pick_reg());
          if ($urandom_range(1) == 1) begin
            op.src_reg1 = pick_reg();
            op.src_reg2 = ra;
            op.use_imm  = 1'b0;
          end
          add_op(op);
        end
        5: begin                                           // Load, store it, reload it
          add_op(make_mem(1'b0, ra, pick_base(), addr));
          add_op(make_mem(1'b1, ra, '0, addr + 8'd16));
          add_op(make_mem(1'b0, rb, '0, addr + 8'd16));
        end
        6: add_op(make_mem(1'b1, ra, pick_base(), addr));
        7: begin                                           // PCS and a user of its result
          op           = '0;
          op.wb.reg_rd = ra;
          op.wb.reg_write = 1'b1;
          op.wb.pcs       = 1'b1;
          add_op(op);
          add_op(make_alu(rb, ra, ra));
        end
        8: add_op(make_mem(1'b0, ra, pick_base(), addr));
        default: begin                                     // Write r0, then read it
          add_op(make_alu('0, rb, pick_reg()));
          add_op(make_alu(ra, '0, '0));
        end
      endcase
    end
  endtask

  //////////////////////////////////////////////////
  // In-order model
  //////////////////////////////////////////////////
  function automatic logic [DATA_W-1:0] alu_model(input alu_op_e op, input logic [DATA_W-1:0] a,
                                                  input logic [DATA_W-1:0] b);
    logic [2*DATA_W-1:0] ext;  // Sign-extended a for the arithmetic shift
    logic [3:0]          sh;
    logic [DATA_W-1:0]   result;
    sh  = b[3:0];
    ext = {{DATA_W{a[DATA_W-1]}}, a} >> sh;
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_AND:    result = a & b;
      ALU_OR:     result = a | b;
      ALU_XOR:    result = a ^ b;
      ALU_SLL:    result = a << sh;
      ALU_SRL:    result = a >> sh;
      ALU_SRA:    result = ext[DATA_W-1:0];
      default:    result = b;            // Pass b
    endcase
    return result;
  endfunction

  task automatic execute_model(input issue_t op);
    logic [DATA_W-1:0]      a;
    logic [DATA_W-1:0]      b;
    logic [DATA_W-1:0]      value;
    logic [DMEM_ADDR_W-1:0] addr;
    a     = model_regs[op.src_reg1];
    b     = op.use_imm ? op.imm : model_regs[op.src_reg2];
    value = alu_model(op.alu_op, a, b);
    addr  = value[DMEM_ADDR_W-1:0];
    if (op.mem_enable && op.mem_write) begin
      model_mem[addr] = model_regs[op.src_reg2];
    end
    if (op.wb.mem_to_reg) begin
      value = model_mem[addr];
    end else if (op.wb.pcs) begin
      value = op.pc_next;
    end
    if (op.wb.reg_write) begin
      expect_q.push_back({op.wb.reg_rd, value});
      expect_count++;
      if (op.wb.reg_rd != '0) begin
        model_regs[op.wb.reg_rd] = value;
      end
    end
  endtask

  // A load or PCS result is late, so its direct user waits one cycle
  function automatic logic late_hazard(input issue_t prev, input issue_t op);
    logic late;
    late = prev.wb.reg_write && (prev.wb.reg_rd != '0) && (prev.wb.mem_to_reg || prev.wb.pcs);
    return late && ((prev.wb.reg_rd == op.src_reg1)
                    || (!op.use_imm && (prev.wb.reg_rd == op.src_reg2)));
  endfunction

  //////////////////////////////////////////////////
  // Driver and checker
  //////////////////////////////////////////////////
  task automatic issue_one(input issue_t op, output int wait_cycles, output logic ok);
    logic ready_seen;
    wait_cycles = 0;
    ok          = 1'b0;
    issue_valid <= 1'b1;
    issue       <= op;
    for (int cycle = 0; cycle < 20; cycle++) begin
      @(negedge clk);
      ready_seen = issue_ready;   // Stable half a cycle before the edge
      @(posedge clk);
      if (ready_seen) begin
        ok = 1'b1;
        break;
      end
      wait_cycles++;
    end
  endtask

  always @(negedge clk) begin
    wb_expect_t exp_wb;
    if (!reset && wb_valid) begin
      wb_count++;
      assert (expect_q.size() > 0) else begin
        error_count++;
        $display("Error at %0t: write-back to r%0d with no operation outstanding",
                 $time, wb_reg);
      end
      if (expect_q.size() > 0) begin
        exp_wb = expect_q.pop_front();
        assert ((wb_reg == exp_wb.rd) && (wb_data == exp_wb.data)) else begin
          mismatch_count++;
          $display("Mismatch at %0t: write-back r%0d = %h, expected r%0d = %h",
                   $time, wb_reg, wb_data, exp_wb.rd, exp_wb.data);
        end
      end
    end
  end

  initial begin
    issue_t op;
    issue_t prev_op;
    logic   have_prev;
    logic   gap;
    logic   ok;
    logic   drained;
    int     wait_cycles;
    int     expected_wait;
    int     prop_failures;
    issue_valid    = 1'b0;
    issue          = '0;
    mismatch_count = 0;
    error_count    = 0;
    wb_count       = 0;
    expect_count   = 0;
    next_pc        = 16'h0100;
    have_prev      = 1'b0;
    prev_op        = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < DMEM_DEPTH; i++) begin
      model_mem[i] = '0;          // The DUT clears its memory in reset
    end
    void'($urandom(93));
    generate_program(400);
    op       = '0;
    op.wb.hlt = 1'b1;             // Program ends in a halt
    add_op(op);

    ok = 1'b0;
    for (int cycle = 0; (cycle < 20) && !ok; cycle++) begin
      @(negedge clk);
      ok = !reset;
    end
    if (!ok) begin
      error_count++;
      $display("Error at %0t: reset was never released", $time);
    end else begin
      @(posedge clk);
      while (ok && (program_q.size() > 0)) begin
        op  = program_q.pop_front();
        gap = ($urandom_range(7) == 0);
        if (gap) begin
          issue_valid <= 1'b0;    // One idle cycle before this operation
          @(posedge clk);
        end
        expected_wait = (have_prev && !gap && late_hazard(prev_op, op)) ? 1 : 0;
        issue_one(op, wait_cycles, ok);
        if (!ok) begin
          error_count++;
          $display("Error at %0t: operation at pc %h was never accepted", $time, op.pc_next);
        end else begin
          execute_model(op);
          if (have_prev) begin
            assert (wait_cycles == expected_wait) else begin
              mismatch_count++;
              $display("Mismatch at %0t: pc %h waited %0d cycles, expected %0d",
                       $time, op.pc_next, wait_cycles, expected_wait);
            end
          end
          prev_op   = op;
          have_prev = 1'b1;
        end
      end
      issue_valid <= 1'b0;
    end

    if (ok) begin
      drained = 1'b0;
      for (int cycle = 0; (cycle < 20) && !drained; cycle++) begin
        @(posedge clk);
        drained = halted && (expect_q.size() == 0);
      end
      if (!drained) begin
        error_count++;
        $display("Error at %0t: halt or outstanding write-backs never completed", $time);
      end
      for (int cycle = 0; cycle < 5; cycle++) begin
        @(negedge clk);
        assert (halted && !issue_ready) else begin
          mismatch_count++;
          $display("Mismatch at %0t: halted %0b issue_ready %0b after halt",
                   $time, halted, issue_ready);
        end
      end
      assert ((wb_count == expect_count) && (expect_q.size() == 0)) else begin
        mismatch_count++;
        $display("Mismatch at %0t: %0d write-backs seen, model expected %0d",
                 $time, wb_count, expect_count);
      end
    end

    prop_failures = DUT.u_props.fail_count;
    $display("Summary: %0d write-backs, %0d mismatches, %0d errors, %0d assertion failures",
             wb_count, mismatch_count, error_count, prop_failures);
    if ((mismatch_count == 0) && (error_count == 0) && (prop_failures == 0)) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
